//--- dl_pkg.sv
`default_nettype none

package dl_pkg;

	////////////////////
	// Link words

	// Two 8-bit symbols per clock, low symbol first on the wire
	typedef logic [15:0] word_t;

	// One control character flag per symbol
	typedef logic [1:0] kmask_t;

	////////////////////
	// Flow control

	typedef logic [7:0] hdr_credit_t;
	typedef logic [11:0] data_credit_t;

	// HdrFC sits in bits 21:14
	// DataFC sits in bits 11:0
	typedef logic [23:0] dllp_payload_t;

	// Credit classes, also the index of the partner credit arrays
	typedef enum logic [1:0] {
		FC_P   = 2'd0,
		FC_NP  = 2'd1,
		FC_CPL = 2'd2
	} fc_class_t;

	// Low three bits of every FC type carry the VC number
	typedef enum logic [7:0] {
		DLLP_ACK           = 8'h00,
		DLLP_NAK           = 8'h10,
		DLLP_INITFC1_P     = 8'h40,
		DLLP_INITFC1_NP    = 8'h50,
		DLLP_INITFC1_CPL   = 8'h60,
		DLLP_INITFC2_P     = 8'hC0,
		DLLP_INITFC2_NP    = 8'hD0,
		DLLP_INITFC2_CPL   = 8'hE0,
		DLLP_UPDATEFC_P    = 8'h80,
		DLLP_UPDATEFC_NP   = 8'h90,
		DLLP_UPDATEFC_CPL  = 8'hA0
	} dllp_type_t;

	typedef enum logic {
		DL_INACTIVE = 1'b0,
		DL_INIT     = 1'b1
	} dl_state_t;

	////////////////////
	// Symbols and constants

	localparam logic [7:0] SYM_COM      = 8'hBC;	// K28.5
	localparam logic [7:0] SYM_SKP      = 8'h1C;	// K28.0
	localparam logic [7:0] SYM_SDP_DLLP = 8'h5C;	// K28.2
	localparam logic [7:0] SYM_END      = 8'hFD;	// K29.7

	// Scrambler LFSR load values and feedback taps
	localparam word_t SCRAMBLER_SEED      = 16'hFFFF;
	localparam word_t SCRAMBLER_AFTER_COM = 16'hE817;
	localparam word_t SCRAMBLER_TAP_MASK  = 16'h001C;

	// DLLP CRC-16
	localparam word_t CRC_POLY = 16'h100B;
	localparam word_t CRC_SEED = 16'hFFFF;

	// Consecutive idle words before flow control init starts
	localparam int IDLE_RUN_LENGTH = 8;

endpackage

`default_nettype wire

//--- dllp_crc16.sv
`timescale 1ns/10ps
`default_nettype none

module dllp_crc16 import dl_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire first_phase,
	input wire second_phase,
	input wire word_t data_first,
	input wire word_t data_second,
	output word_t crc
);

	// Running remainder between the two phases
	word_t rem;

	// Two bytes, low byte first, each byte LSB first
	function automatic word_t crc_step(input word_t seed, input word_t data);
		word_t r;
		logic fb;
		r = seed;
		for (int i = 0; i < 16; i++) begin
			fb = r[15] ^ data[i];
			r = {r[14:0], 1'b0};
			if (fb)
				r = r ^ CRC_POLY;
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rem <= CRC_SEED;
		end else if (first_phase) begin
			// Type and payload byte 2 always start from the seed
			rem <= crc_step(CRC_SEED, data_first);
		end else if (second_phase) begin
			rem <= crc_step(rem, data_second);
		end
	end

	// Final value is the inverted remainder in reversed bit order
	always_comb begin
		for (int i = 0; i < 16; i++)
			crc[i] = ~rem[15 - i];
	end

endmodule

`default_nettype wire

//--- rx_descrambler.sv
`timescale 1ns/10ps
`default_nettype none

module rx_descrambler import dl_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire word_t rx_data,
	input wire kmask_t rx_charisk,
	input wire kmask_t rx_err,
	output word_t desc_data,
	output kmask_t desc_k,
	output logic desc_err
);

	word_t scr_state;
	word_t scr_next;
	word_t scr_bits;

	logic com_low;
	logic skp_high;
	logic skp_pair;

	////////////////////
	// LFSR, 16 steps per word

	always_comb begin : lfsr_unroll
		word_t lfsr;
		lfsr = scr_state;
		for (int i = 0; i < 16; i++) begin
			// Output bit is the top of the register
			scr_bits[i] = lfsr[15];
			if (lfsr[15])
				lfsr = {lfsr[14:0] ^ SCRAMBLER_TAP_MASK[14:0], 1'b1};
			else
				lfsr = {lfsr[14:0], 1'b0};
		end
		scr_next = lfsr;
	end

	// Ordered set detection
	assign com_low  = rx_charisk[0] && (rx_data[7:0] == SYM_COM);
	assign skp_high = rx_charisk[1] && (rx_data[15:8] == SYM_SKP);
	assign skp_pair = (rx_charisk == 2'b11) && (rx_data == {SYM_SKP, SYM_SKP});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scr_state <= SCRAMBLER_SEED;
			desc_data <= '0;
			desc_k    <= '0;
			desc_err  <= 1'b0;
		end else begin
			// K symbols pass unchanged, data symbols get their scrambler byte
			desc_data[7:0]  <= rx_charisk[0] ? rx_data[7:0] : rx_data[7:0] ^ scr_bits[7:0];
			desc_data[15:8] <= rx_charisk[1] ? rx_data[15:8] : rx_data[15:8] ^ scr_bits[15:8];
			desc_k   <= rx_charisk;
			desc_err <= |rx_err;

			// COM reloads the LFSR
			if (com_low)
				scr_state <= skp_high ? SCRAMBLER_SEED : SCRAMBLER_AFTER_COM;
			// SKP pair freezes it
			else if (!skp_pair)
				scr_state <= scr_next;
		end
	end

	// Zero state would lock the LFSR forever
	a_lfsr_live: assert property (@(posedge clk) disable iff (!rst_n)
		scr_state != '0);

endmodule

`default_nettype wire

//--- dllp_rx_parser.sv
`timescale 1ns/10ps
`default_nettype none

module dllp_rx_parser import dl_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire link_up,
	input wire word_t desc_data,
	input wire kmask_t desc_k,
	input wire desc_err,
	output logic [2:0] partner_fc_valid,
	output hdr_credit_t [2:0] partner_fc_hdr,
	output data_credit_t [2:0] partner_fc_data
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PAYLOAD1,
		RX_PAYLOAD2,
		RX_CRC_END
	} rx_state_t;

	rx_state_t rx_state;
	dllp_type_t rx_type;
	dllp_payload_t rx_payload;
	logic [7:0] rx_crc_hi;
	logic dllp_valid;
	word_t crc_expected;

	fc_class_t hit_cls;
	logic hit;

	// CRC runs over word 1 then word 2 as they arrive
	dllp_crc16 u_crc (
		.clk(clk),
		.rst_n(rst_n),
		.first_phase(rx_state == RX_PAYLOAD1),
		.second_phase(rx_state == RX_PAYLOAD2),
		.data_first({desc_data[7:0], rx_type}),
		.data_second({desc_data[7:0], rx_payload[15:8]}),
		.crc(crc_expected)
	);

	////////////////////
	// Framing FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state   <= RX_IDLE;
			dllp_valid <= 1'b0;
		end else begin
			dllp_valid <= 1'b0;
			case (rx_state)
				RX_IDLE: begin
					// SDP in the low symbol opens a DLLP
					if (desc_k == 2'b01 && desc_data[7:0] == SYM_SDP_DLLP)
						rx_state <= RX_PAYLOAD1;
				end
				RX_PAYLOAD1: begin
					// Payload words carry no K symbols
					rx_state <= (desc_k == 2'b00) ? RX_PAYLOAD2 : RX_IDLE;
				end
				RX_PAYLOAD2: begin
					rx_state <= (desc_k == 2'b00) ? RX_CRC_END : RX_IDLE;
				end
				RX_CRC_END: begin
					// Low CRC byte then END
					if (desc_k == 2'b10 && desc_data[15:8] == SYM_END && !desc_err && link_up &&
						crc_expected == {rx_crc_hi, desc_data[7:0]})
						dllp_valid <= 1'b1;
					rx_state <= RX_IDLE;
				end
				default: rx_state <= RX_IDLE;
			endcase

			// Symbol error or link loss drops any DLLP in flight
			if (desc_err || !link_up)
				rx_state <= RX_IDLE;
		end
	end

	// Field capture
	always_ff @(posedge clk) begin
		case (rx_state)
			RX_IDLE: rx_type <= dllp_type_t'(desc_data[15:8]);
			RX_PAYLOAD1: rx_payload[23:8] <= {desc_data[7:0], desc_data[15:8]};
			RX_PAYLOAD2: begin
				rx_payload[7:0] <= desc_data[7:0];
				rx_crc_hi <= desc_data[15:8];
			end
			default: ;
		endcase
	end

	////////////////////
	// Partner credits

	// Only InitFC1 for VC0 is taken
	always_comb begin
		hit = 1'b1;
		hit_cls = FC_P;
		case (rx_type)
			DLLP_INITFC1_P:   hit_cls = FC_P;
			DLLP_INITFC1_NP:  hit_cls = FC_NP;
			DLLP_INITFC1_CPL: hit_cls = FC_CPL;
			default:          hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			partner_fc_valid <= '0;
			partner_fc_hdr   <= '0;
			partner_fc_data  <= '0;
		end else if (dllp_valid && hit) begin
			partner_fc_valid[hit_cls] <= 1'b1;
			partner_fc_hdr[hit_cls]   <= rx_payload[21:14];
			partner_fc_data[hit_cls]  <= rx_payload[11:0];
		end
	end

	// A good DLLP follows SDP then two payload words then END on back-to-back words
	a_dllp_framing: assert property (@(posedge clk) disable iff (!rst_n)
		dllp_valid |-> $past(desc_k, 4) == 2'b01 && $past(desc_k, 3) == 2'b00 &&
			$past(desc_k, 2) == 2'b00 && $past(desc_k) == 2'b10);

endmodule

`default_nettype wire

//--- dl_link_control.sv
`timescale 1ns/10ps
`default_nettype none

module dl_link_control import dl_pkg::*; #(
	parameter int adv_hdr_p = 32,
	parameter int adv_data_p = 2048,
	parameter int adv_hdr_np = 32,
	parameter int adv_data_np = 2048,
	parameter int adv_hdr_cpl = 0,
	parameter int adv_data_cpl = 0
) (
	input wire clk,
	input wire rst_n,
	input wire link_up,
	input wire word_t desc_data,
	input wire kmask_t desc_k,
	input wire desc_err,
	input wire dllp_ack,
	output logic dllp_req,
	output dllp_type_t dllp_type,
	output dllp_payload_t dllp_payload,
	output logic link_init
);

	localparam int RUN_W = $clog2(IDLE_RUN_LENGTH + 1);

	dl_state_t dl_state;
	fc_class_t cur_cls;
	fc_class_t load_cls;
	logic [RUN_W-1:0] idle_run;
	logic [RUN_W-1:0] idle_run_next;
	logic idle_word;
	logic run_done;
	logic load_dllp;

	hdr_credit_t load_hdr;
	data_credit_t load_data;
	dllp_type_t load_type;

	////////////////////
	// Idle detection

	// Logical idle is a zero data word with no K and no error
	assign idle_word = (desc_data == '0) && (desc_k == '0) && !desc_err;
	assign idle_run_next = idle_word ? idle_run + 1'b1 : '0;
	assign run_done = link_up && (idle_run_next == RUN_W'(IDLE_RUN_LENGTH));

	// First DLLP on entry, next one on every ack
	assign load_dllp = (dl_state == DL_INACTIVE && run_done) ||
		(dl_state == DL_INIT && link_up && dllp_ack);

	// P then NP then CPL then back to P
	always_comb begin
		if (dl_state == DL_INACTIVE)
			load_cls = FC_P;
		else if (cur_cls == FC_P)
			load_cls = FC_NP;
		else if (cur_cls == FC_NP)
			load_cls = FC_CPL;
		else
			load_cls = FC_P;
	end

	// Our advertised credits per class
	always_comb begin
		case (load_cls)
			FC_P: begin
				load_type = DLLP_INITFC1_P;
				load_hdr  = hdr_credit_t'(adv_hdr_p);
				load_data = data_credit_t'(adv_data_p);
			end
			FC_NP: begin
				load_type = DLLP_INITFC1_NP;
				load_hdr  = hdr_credit_t'(adv_hdr_np);
				load_data = data_credit_t'(adv_data_np);
			end
			default: begin
				load_type = DLLP_INITFC1_CPL;
				load_hdr  = hdr_credit_t'(adv_hdr_cpl);
				load_data = data_credit_t'(adv_data_cpl);
			end
		endcase
	end

	////////////////////
	// Link state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dl_state <= DL_INACTIVE;
			idle_run <= '0;
			dllp_req <= 1'b0;
			cur_cls  <= FC_P;
		end else begin
			case (dl_state)
				DL_INACTIVE: begin
					idle_run <= link_up ? idle_run_next : '0;
					if (run_done) begin
						dl_state <= DL_INIT;
						idle_run <= '0;
					end
				end
				default: begin
					if (!link_up) begin
						dl_state <= DL_INACTIVE;
						dllp_req <= 1'b0;
					end
				end
			endcase
			if (load_dllp) begin
				dllp_req <= 1'b1;
				cur_cls  <= load_cls;
			end
		end
	end

	// DLLP contents stay put until the next load
	always_ff @(posedge clk) begin
		if (load_dllp) begin
			dllp_type    <= load_type;
			dllp_payload <= {2'b00, load_hdr, 2'b00, load_data};
		end
	end

	assign link_init = (dl_state == DL_INIT);

	a_no_req_inactive: assert property (@(posedge clk) disable iff (!rst_n)
		dl_state == DL_INACTIVE |-> !dllp_req);

endmodule

`default_nettype wire

//--- dllp_tx_framer.sv
`timescale 1ns/10ps
`default_nettype none

module dllp_tx_framer import dl_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire dllp_req,
	input wire dllp_type_t dllp_type,
	input wire dllp_payload_t dllp_payload,
	input wire tx_skip_req,
	input wire tx_skip_done,
	output logic dllp_ack,
	output word_t tx_data,
	output kmask_t tx_charisk,
	output logic tx_skip_ack
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_SKIP,
		TX_WORD1,
		TX_WORD2,
		TX_WORD3
	} tx_state_t;

	tx_state_t tx_state;
	word_t tx_crc;
	logic start;

	// DLLP may only start from idle when no skip is pending
	assign start = (tx_state == TX_IDLE) && !tx_skip_req && dllp_req;

	// CRC of type and payload, ready by word 2
	dllp_crc16 u_crc (
		.clk(clk),
		.rst_n(rst_n),
		.first_phase(start),
		.second_phase(tx_state == TX_WORD1),
		.data_first({dllp_payload[23:16], dllp_type}),
		.data_second({dllp_payload[7:0], dllp_payload[15:8]}),
		.crc(tx_crc)
	);

	////////////////////
	// Transmit FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_state    <= TX_IDLE;
			tx_data     <= '0;
			tx_charisk  <= '0;
			tx_skip_ack <= 1'b0;
			dllp_ack    <= 1'b0;
		end else begin
			// Handshake pulses last one cycle
			tx_skip_ack <= 1'b0;
			dllp_ack    <= 1'b0;
			case (tx_state)
				TX_IDLE: begin
					tx_data    <= '0;
					tx_charisk <= '0;
					// Skip wins over a new DLLP
					if (tx_skip_req) begin
						tx_skip_ack <= 1'b1;
						tx_state    <= TX_SKIP;
					end else if (dllp_req) begin
						tx_data    <= {dllp_type, SYM_SDP_DLLP};
						tx_charisk <= 2'b01;
						tx_state   <= TX_WORD1;
					end
				end
				TX_SKIP: begin
					// PHY owns the lane until done
					tx_data    <= '0;
					tx_charisk <= '0;
					if (tx_skip_done)
						tx_state <= TX_IDLE;
				end
				TX_WORD1: begin
					tx_data    <= {dllp_payload[15:8], dllp_payload[23:16]};
					tx_charisk <= 2'b00;
					tx_state   <= TX_WORD2;
				end
				TX_WORD2: begin
					// Controller may reload after this word
					tx_data    <= {tx_crc[15:8], dllp_payload[7:0]};
					tx_charisk <= 2'b00;
					dllp_ack   <= 1'b1;
					tx_state   <= TX_WORD3;
				end
				TX_WORD3: begin
					tx_data    <= {SYM_END, tx_crc[7:0]};
					tx_charisk <= 2'b10;
					tx_state   <= TX_IDLE;
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	a_skip_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		tx_skip_ack |=> !tx_skip_ack);

endmodule

`default_nettype wire

//--- pcie_data_link.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_data_link import dl_pkg::*; #(
	parameter int adv_hdr_p = 32,
	parameter int adv_data_p = 2048,
	parameter int adv_hdr_np = 32,
	parameter int adv_data_np = 2048,
	// Zero advertises unlimited completions
	parameter int adv_hdr_cpl = 0,
	parameter int adv_data_cpl = 0
) (
	input wire clk,
	input wire rst_n,
	input wire link_up,
	input wire word_t rx_data,
	input wire kmask_t rx_charisk,
	input wire kmask_t rx_err,
	input wire tx_skip_req,
	input wire tx_skip_done,
	output wire word_t tx_data,
	output wire kmask_t tx_charisk,
	output wire tx_skip_ack,
	output wire link_init,
	output wire [2:0] partner_fc_valid,
	output wire hdr_credit_t [2:0] partner_fc_hdr,
	output wire data_credit_t [2:0] partner_fc_data
);

	// Descrambled receive word
	wire word_t desc_data;
	wire kmask_t desc_k;
	wire desc_err;

	// DLLP request path
	wire dllp_req;
	wire dllp_ack;
	wire dllp_type_t dllp_type;
	wire dllp_payload_t dllp_payload;

	rx_descrambler u_desc (
		.clk(clk), .rst_n(rst_n),
		.rx_data(rx_data), .rx_charisk(rx_charisk), .rx_err(rx_err),
		.desc_data(desc_data), .desc_k(desc_k), .desc_err(desc_err)
	);

	dllp_rx_parser u_parser (
		.clk(clk), .rst_n(rst_n), .link_up(link_up),
		.desc_data(desc_data), .desc_k(desc_k), .desc_err(desc_err),
		.partner_fc_valid(partner_fc_valid),
		.partner_fc_hdr(partner_fc_hdr),
		.partner_fc_data(partner_fc_data)
	);

	dl_link_control #(
		.adv_hdr_p(adv_hdr_p), .adv_data_p(adv_data_p),
		.adv_hdr_np(adv_hdr_np), .adv_data_np(adv_data_np),
		.adv_hdr_cpl(adv_hdr_cpl), .adv_data_cpl(adv_data_cpl)
	) u_ctrl (
		.clk(clk), .rst_n(rst_n), .link_up(link_up),
		.desc_data(desc_data), .desc_k(desc_k), .desc_err(desc_err),
		.dllp_ack(dllp_ack), .dllp_req(dllp_req),
		.dllp_type(dllp_type), .dllp_payload(dllp_payload),
		.link_init(link_init)
	);

	dllp_tx_framer u_framer (
		.clk(clk), .rst_n(rst_n),
		.dllp_req(dllp_req), .dllp_type(dllp_type), .dllp_payload(dllp_payload),
		.tx_skip_req(tx_skip_req), .tx_skip_done(tx_skip_done),
		.dllp_ack(dllp_ack), .tx_data(tx_data), .tx_charisk(tx_charisk),
		.tx_skip_ack(tx_skip_ack)
	);

endmodule

`default_nettype wire

//--- tb_dl_model.svh
`ifndef TB_DL_MODEL_SVH
`define TB_DL_MODEL_SVH

////////////////////
// Scrambler model

// Runs the LFSR over one word and returns the new state
// bits collects the 16 output bits with the first symbol LSB in bit 0
function automatic word_t lfsr_advance(input word_t st, output word_t bits);
	for (int i = 0; i < 16; i++) begin
		bits[i] = st[15];
		if (st[15])
			st = ((st ^ SCRAMBLER_TAP_MASK) << 1) | 16'h0001;
		else
			st = st << 1;
	end
	return st;
endfunction

// State after one word on the wire
function automatic word_t scr_update(input word_t st, input word_t d, input kmask_t k);
	word_t bits;
	// COM reloads the seed when SKP follows and the after-COM value otherwise
	if (k[0] && d[7:0] == SYM_COM)
		return (k[1] && d[15:8] == SYM_SKP) ? SCRAMBLER_SEED : SCRAMBLER_AFTER_COM;
	// SKP pair freezes the LFSR
	if (k == 2'b11 && d == {SYM_SKP, SYM_SKP})
		return st;
	return lfsr_advance(st, bits);
endfunction

// Data symbols get their 8 scrambler bits while K symbols pass
function automatic word_t scramble_word(input word_t st, input word_t d, input kmask_t k);
	word_t bits;
	word_t out;
	void'(lfsr_advance(st, bits));
	out[7:0] = k[0] ? d[7:0] : d[7:0] ^ bits[7:0];
	out[15:8] = k[1] ? d[15:8] : d[15:8] ^ bits[15:8];
	return out;
endfunction

////////////////////
// DLLP model

// Bytes go in as type then byte 2 then byte 1 then byte 0 with each LSB first
function automatic word_t dllp_crc(input dllp_type_t dtype, input dllp_payload_t pl);
	logic [31:0] stream;
	word_t r;
	word_t res;
	logic fb;
	stream = {pl[7:0], pl[15:8], pl[23:16], dtype};
	r = CRC_SEED;
	for (int i = 0; i < 32; i++) begin
		fb = r[15] ^ stream[i];
		r = r << 1;
		if (fb)
			r = r ^ CRC_POLY;
	end
	// Complemented and bit reversed
	for (int i = 0; i < 16; i++)
		res[i] = ~r[15 - i];
	return res;
endfunction

function automatic dllp_payload_t fc_payload(input hdr_credit_t hdr, input data_credit_t data);
	return {2'b00, hdr, 2'b00, data};
endfunction

// Word idx of a DLLP on the link
function automatic word_t dllp_word(input dllp_type_t dtype, input dllp_payload_t pl,
	input int idx);
	word_t c;
	c = dllp_crc(dtype, pl);
	case (idx)
		0: return {dtype, SYM_SDP_DLLP};
		1: return {pl[15:8], pl[23:16]};
		2: return {c[15:8], pl[7:0]};
		default: return {SYM_END, c[7:0]};
	endcase
endfunction

function automatic kmask_t dllp_kmask(input int idx);
	case (idx)
		0: return 2'b01;
		3: return 2'b10;
		default: return 2'b00;
	endcase
endfunction

// Stimulus random source
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

//--- tb_pcie_data_link.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pcie_data_link import dl_pkg::*; ();

	localparam int ADV_HDR_P = 32;
	localparam int ADV_DATA_P = 2048;
	localparam int ADV_HDR_NP = 32;
	localparam int ADV_DATA_NP = 2048;
	localparam int ADV_HDR_CPL = 0;
	localparam int ADV_DATA_CPL = 0;
	localparam int ROWS = 10;
	localparam int WAIT_LIMIT = 12;

	typedef enum logic [1:0] {
		FAULT_NONE,
		FAULT_BAD_CRC,
		FAULT_K_PAYLOAD,
		FAULT_RX_ERR
	} fault_t;

	typedef struct {
		dllp_type_t dtype;
		fc_class_t cls;
		fault_t fault;
		logic expect_update;
		hdr_credit_t hdr;
		data_credit_t data;
	} stim_row_t;

	logic clk;
	logic rst_n;
	logic link_up;
	word_t rx_data;
	kmask_t rx_charisk;
	kmask_t rx_err;
	logic tx_skip_req;
	logic tx_skip_done;

	wire word_t tx_data;
	wire kmask_t tx_charisk;
	wire tx_skip_ack;
	wire link_init;
	wire [2:0] partner_fc_valid;
	wire hdr_credit_t [2:0] partner_fc_hdr;
	wire data_credit_t [2:0] partner_fc_data;

	stim_row_t table_rows [ROWS];
	word_t scr_model;
	logic [31:0] rng;

	// Expected partner credit state
	logic [2:0] exp_valid;
	hdr_credit_t exp_hdr [3];
	data_credit_t exp_data [3];

	`include "tb_dl_model.svh"

	pcie_data_link #(
		.adv_hdr_p(ADV_HDR_P), .adv_data_p(ADV_DATA_P),
		.adv_hdr_np(ADV_HDR_NP), .adv_data_np(ADV_DATA_NP),
		.adv_hdr_cpl(ADV_HDR_CPL), .adv_data_cpl(ADV_DATA_CPL)
	) u_dut (
		.clk(clk), .rst_n(rst_n), .link_up(link_up),
		.rx_data(rx_data), .rx_charisk(rx_charisk), .rx_err(rx_err),
		.tx_skip_req(tx_skip_req), .tx_skip_done(tx_skip_done),
		.tx_data(tx_data), .tx_charisk(tx_charisk), .tx_skip_ack(tx_skip_ack),
		.link_init(link_init), .partner_fc_valid(partner_fc_valid),
		.partner_fc_hdr(partner_fc_hdr), .partner_fc_data(partner_fc_data)
	);

	always #50 clk = ~clk;

	////////////////////
	// Checks

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_tx_word(input word_t exp_d, input kmask_t exp_k, input string what);
		if (tx_data !== exp_d || tx_charisk !== exp_k)
			abort_run($sformatf("ERROR at %0d ns: %s got %h/%b expected %h/%b",
				$time, what, tx_data, tx_charisk, exp_d, exp_k));
	endtask

	task automatic check_credit(input fc_class_t cls, input hdr_credit_t exp_h,
		input data_credit_t exp_d);
		if (partner_fc_hdr[cls] !== exp_h || partner_fc_data[cls] !== exp_d)
			abort_run($sformatf("ERROR at %0d ns: %s credits got %h/%h expected %h/%h",
				$time, cls.name(), partner_fc_hdr[cls], partner_fc_data[cls], exp_h, exp_d));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0d ns: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_all_credits(input string tag);
		for (int c = 0; c < 3; c++) begin
			check_bit(partner_fc_valid[c], exp_valid[c], $sformatf("%s valid %0d", tag, c));
			check_credit(fc_class_t'(c), exp_hdr[c], exp_data[c]);
		end
	endtask

	////////////////////
	// Stimulus helpers

	// One receive word per clock, scrambled by the model
	task automatic send_rx(input word_t d, input kmask_t k, input kmask_t e);
		word_t sd;
		sd = scramble_word(scr_model, d, k);
		scr_model = scr_update(scr_model, d, k);
		@(posedge clk);
		rx_data <= sd;
		rx_charisk <= k;
		rx_err <= e;
	endtask

	function automatic dllp_type_t adv_type(input fc_class_t cls);
		case (cls)
			FC_P: return DLLP_INITFC1_P;
			FC_NP: return DLLP_INITFC1_NP;
			default: return DLLP_INITFC1_CPL;
		endcase
	endfunction

	function automatic dllp_payload_t adv_payload(input fc_class_t cls);
		case (cls)
			FC_P: return fc_payload(hdr_credit_t'(ADV_HDR_P), data_credit_t'(ADV_DATA_P));
			FC_NP: return fc_payload(hdr_credit_t'(ADV_HDR_NP), data_credit_t'(ADV_DATA_NP));
			default: return fc_payload(hdr_credit_t'(ADV_HDR_CPL), data_credit_t'(ADV_DATA_CPL));
		endcase
	endfunction

	// Ends on the negedge that shows an SDP word
	task automatic wait_sdp(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!(tx_charisk == 2'b01 && tx_data[7:0] == SYM_SDP_DLLP)) begin
			n++;
			if (n > WAIT_LIMIT)
				abort_run({"timeout waiting for the start of ", what});
			@(negedge clk);
		end
	endtask

	// Four consecutive words of our own InitFC1
	task automatic expect_dllp(input fc_class_t cls, input logic raise_skip);
		dllp_type_t t;
		dllp_payload_t p;
		string what;
		t = adv_type(cls);
		p = adv_payload(cls);
		what = t.name();
		wait_sdp(what);
		check_tx_word(dllp_word(t, p, 0), dllp_kmask(0), {what, " word 0"});
		for (int i = 1; i < 4; i++) begin
			@(posedge clk);
			// Skip request lands in the middle of the DLLP
			if (raise_skip && i == 1)
				tx_skip_req <= 1'b1;
			@(negedge clk);
			check_tx_word(dllp_word(t, p, i), dllp_kmask(i), $sformatf("%s word %0d", what, i));
		end
	endtask

	task automatic set_row(input int i, input dllp_type_t t, input fc_class_t c,
		input fault_t f, input logic e);
		rng = xorshift32(rng);
		table_rows[i].dtype = t;
		table_rows[i].cls = c;
		table_rows[i].fault = f;
		table_rows[i].expect_update = e;
		table_rows[i].hdr = rng[7:0];
		table_rows[i].data = rng[27:16];
	endtask

	task automatic fill_table();
		set_row(0, DLLP_INITFC1_P, FC_P, FAULT_NONE, 1'b1);
		set_row(1, DLLP_INITFC1_NP, FC_NP, FAULT_NONE, 1'b1);
		set_row(2, DLLP_INITFC1_CPL, FC_CPL, FAULT_NONE, 1'b1);
		set_row(3, DLLP_INITFC1_P, FC_P, FAULT_BAD_CRC, 1'b0);
		set_row(4, DLLP_INITFC1_P, FC_P, FAULT_NONE, 1'b1);
		set_row(5, DLLP_INITFC1_NP, FC_NP, FAULT_K_PAYLOAD, 1'b0);
		set_row(6, DLLP_INITFC1_NP, FC_NP, FAULT_NONE, 1'b1);
		set_row(7, DLLP_INITFC1_CPL, FC_CPL, FAULT_RX_ERR, 1'b0);
		// Good CRC but not an InitFC1
		set_row(8, DLLP_UPDATEFC_P, FC_P, FAULT_NONE, 1'b0);
		set_row(9, DLLP_INITFC1_CPL, FC_CPL, FAULT_NONE, 1'b1);
	endtask

	////////////////////
	// Test phases

	task automatic bring_up_link();
		int n;
		@(posedge clk);
		link_up <= 1'b1;
		send_rx({SYM_SKP, SYM_COM}, 2'b11, 2'b00);
		repeat (IDLE_RUN_LENGTH) send_rx('0, '0, '0);
		// Last idle word not yet through the descrambler
		@(negedge clk);
		check_bit(link_init, 1'b0, "link_init before the idle run");
		n = 0;
		while (!link_init) begin
			if (n == WAIT_LIMIT)
				abort_run("timeout waiting for link_init after the idle run");
			@(negedge clk);
			n++;
		end
		// P, NP, CPL twice over
		for (int r = 0; r < 6; r++)
			expect_dllp(fc_class_t'(r % 3), 1'b0);
	endtask

	task automatic check_skip();
		int n;
		expect_dllp(FC_P, 1'b1);
		n = 0;
		@(negedge clk);
		while (!tx_skip_ack) begin
			check_tx_word('0, '0, "word before skip ack");
			n++;
			if (n > WAIT_LIMIT)
				abort_run("timeout waiting for the skip ack");
			@(negedge clk);
		end
		check_tx_word('0, '0, "word at skip ack");
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			if (i == 0)
				tx_skip_req <= 1'b0;
			@(negedge clk);
			check_bit(tx_skip_ack, 1'b0, "skip ack after its pulse");
			check_tx_word('0, '0, "word during skip");
		end
		@(posedge clk);
		tx_skip_done <= 1'b1;
		@(negedge clk);
		check_tx_word('0, '0, "word at skip done");
		@(posedge clk);
		tx_skip_done <= 1'b0;
		// Order resumes where it stopped
		expect_dllp(FC_NP, 1'b0);
	endtask

	task automatic apply_row(input int i);
		stim_row_t row;
		dllp_payload_t pl;
		word_t w;
		kmask_t k;
		kmask_t e;
		logic hit;
		int n;
		row = table_rows[i];
		pl = fc_payload(row.hdr, row.data);
		send_rx({SYM_SKP, SYM_COM}, 2'b11, 2'b00);
		for (int j = 0; j < 4; j++) begin
			w = dllp_word(row.dtype, pl, j);
			k = dllp_kmask(j);
			e = 2'b00;
			if (row.fault == FAULT_BAD_CRC && j == 3)
				w = w ^ 16'h0001;
			if (row.fault == FAULT_K_PAYLOAD && j == 1)
				k = 2'b01;
			if (row.fault == FAULT_RX_ERR && j == 2)
				e = 2'b01;
			send_rx(w, k, e);
		end
		if (row.expect_update) begin
			exp_valid[row.cls] = 1'b1;
			exp_hdr[row.cls] = row.hdr;
			exp_data[row.cls] = row.data;
			hit = 1'b0;
			n = 0;
			while (!hit) begin
				if (n == WAIT_LIMIT)
					abort_run($sformatf("timeout waiting for the credit update of row %0d", i));
				send_rx('0, '0, '0);
				@(negedge clk);
				hit = partner_fc_valid[row.cls] && partner_fc_hdr[row.cls] == row.hdr &&
					partner_fc_data[row.cls] == row.data;
				n++;
			end
		end else begin
			// An update would land within three cycles of word 3
			repeat (4) send_rx('0, '0, '0);
			@(negedge clk);
		end
		check_all_credits($sformatf("row %0d", i));
	endtask

	task automatic check_link_drop();
		wait_sdp("DLLP before link drop");
		@(posedge clk);
		link_up <= 1'b0;
		@(negedge clk);
		check_bit(tx_charisk == 2'b00, 1'b1, "word 1 kmask after link drop");
		@(negedge clk);
		check_bit(link_init, 1'b0, "link_init after link drop");
		check_bit(tx_charisk == 2'b00, 1'b1, "word 2 kmask after link drop");
		@(negedge clk);
		// DLLP in flight still closes with END
		check_bit(tx_charisk == 2'b10 && tx_data[15:8] == SYM_END, 1'b1,
			"word 3 after link drop");
		repeat (8) begin
			@(negedge clk);
			check_tx_word('0, '0, "word after link drop");
			check_bit(tx_skip_ack, 1'b0, "skip ack after link drop");
		end
	endtask

	////////////////////
	// Main sequence

	initial begin : main
		clk = 1'b0;
		rst_n = 1'b0;
		link_up = 1'b0;
		rx_data = '0;
		rx_charisk = '0;
		rx_err = '0;
		tx_skip_req = 1'b0;
		tx_skip_done = 1'b0;
		scr_model = SCRAMBLER_SEED;
		rng = 32'h5be4_d438;
		exp_valid = '0;
		for (int c = 0; c < 3; c++) begin
			exp_hdr[c] = '0;
			exp_data[c] = '0;
		end
		fill_table();

		// Two cycles of reset
		@(posedge clk);
		@(negedge clk);
		check_tx_word('0, '0, "word in reset");
		check_bit(tx_skip_ack, 1'b0, "skip ack in reset");
		check_bit(link_init, 1'b0, "link_init in reset");
		check_all_credits("reset");
		@(posedge clk);
		rst_n <= 1'b1;

		bring_up_link();
		check_skip();
		for (int i = 0; i < ROWS; i++)
			apply_row(i);
		check_link_drop();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- pcie_data_link.f
+incdir+.
dl_pkg.sv
dllp_crc16.sv
rx_descrambler.sv
dllp_rx_parser.sv
dl_link_control.sv
dllp_tx_framer.sv
pcie_data_link.sv
tb_pcie_data_link.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_pcie_data_link \
	-f pcie_data_link.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }
